//--- hw/vga_pkg.sv
package vga_pkg;

  // screen position wide enough for any common raster
  typedef logic [11:0] coord_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // pixel stream word that carries its own coordinates
  typedef struct packed {
    coord_t hcount;
    coord_t vcount;
    logic   hsync;
    logic   vsync;
    logic   hblnk;
    logic   vblnk;
    logic   frame_start;
    rgb_t   rgb;
  } pix_t;

  localparam rgb_t RGB_BLACK = '{r: 4'h0, g: 4'h0, b: 4'h0};

endpackage

//--- hw/game_pkg.sv
package game_pkg;

  typedef enum logic [1:0] {
    MENU = 2'd0,
    PLAY = 2'd1,
    OVER = 2'd2
  } game_mode_t;

  // remaining hit points
  typedef logic [3:0] hp_t;

  // fixed palette
  localparam vga_pkg::rgb_t COL_MENU     = '{r: 4'h0, g: 4'h0, b: 4'h6};
  localparam vga_pkg::rgb_t COL_ARENA    = '{r: 4'h0, g: 4'h0, b: 4'h0};
  localparam vga_pkg::rgb_t COL_BORDER   = '{r: 4'hf, g: 4'hf, b: 4'hf};
  localparam vga_pkg::rgb_t COL_OUTSIDE  = '{r: 4'h8, g: 4'h8, b: 4'h8};
  localparam vga_pkg::rgb_t COL_OBSTACLE = '{r: 4'hf, g: 4'h0, b: 4'h0};
  localparam vga_pkg::rgb_t COL_HP       = '{r: 4'h0, g: 4'hf, b: 4'h0};
  localparam vga_pkg::rgb_t COL_OVER     = '{r: 4'h6, g: 4'h0, b: 4'h0};

endpackage

//--- hw/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic          pclk,
  input  logic          rst,
  output vga_pkg::pix_t pix
);

  import vga_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  coord_t h_next;
  coord_t v_next;

  // all flags of one raster position
  function automatic pix_t decode(input coord_t h, input coord_t v);
    pix_t p;
    p.hcount      = h;
    p.vcount      = v;
    p.hsync       = (h >= H_ACTIVE + H_FRONT) && (h < H_ACTIVE + H_FRONT + H_SYNC);
    p.vsync       = (v >= V_ACTIVE + V_FRONT) && (v < V_ACTIVE + V_FRONT + V_SYNC);
    p.hblnk       = (h >= H_ACTIVE);
    p.vblnk       = (v >= V_ACTIVE);
    p.frame_start = (h == '0) && (v == '0);
    p.rgb         = RGB_BLACK;
    return p;
  endfunction

  always_comb begin
    h_next = pix.hcount + 1'b1;
    v_next = pix.vcount;
    if (pix.hcount == coord_t'(H_TOTAL - 1)) begin
      h_next = '0;
      if (pix.vcount == coord_t'(V_TOTAL - 1)) begin
        v_next = '0;
      end else begin
        v_next = pix.vcount + 1'b1;
      end
    end
  end

  // counters live in the output word itself
  always_ff @(posedge pclk) begin
    if (rst) begin
      pix <= decode('0, '0);
    end else begin
      pix <= decode(h_next, v_next);
    end
  end

endmodule

//--- hw/draw_background.sv
`timescale 1ns/1ps

module draw_background #(
  parameter int TOP_LINE    = 120,
  parameter int BOTTOM_LINE = 360,
  parameter int LEFT_LINE   = 160,
  parameter int RIGHT_LINE  = 480,
  parameter int BORDER      = 4
) (
  input  logic                pclk,
  input  logic                rst,
  input  vga_pkg::pix_t       pix_in,
  input  logic                game_button,
  input  logic                menu_button,
  input  logic                game_over,
  output game_pkg::game_mode_t mode,
  output vga_pkg::pix_t       pix_out
);

  import vga_pkg::*;
  import game_pkg::*;

  game_mode_t mode_next;
  logic       in_arena;
  logic       in_interior;
  rgb_t       rgb;

  // mode only moves at the first pixel of a frame
  always_comb begin
    mode_next = mode;
    if (pix_in.frame_start) begin
      if (menu_button) begin
        mode_next = MENU;
      end else begin
        case (mode)
          MENU:    if (game_button) mode_next = PLAY;
          PLAY:    if (game_over) mode_next = OVER;
          default: mode_next = mode;
        endcase
      end
    end
  end

  assign in_arena = (pix_in.hcount >= LEFT_LINE) && (pix_in.hcount < RIGHT_LINE) &&
                    (pix_in.vcount >= TOP_LINE) && (pix_in.vcount < BOTTOM_LINE);

  assign in_interior = (pix_in.hcount >= LEFT_LINE + BORDER) &&
                       (pix_in.hcount < RIGHT_LINE - BORDER) &&
                       (pix_in.vcount >= TOP_LINE + BORDER) &&
                       (pix_in.vcount < BOTTOM_LINE - BORDER);

  // next mode used so the frame's first pixel matches the rest
  always_comb begin
    if (pix_in.hblnk || pix_in.vblnk) begin
      rgb = RGB_BLACK;
    end else if (mode_next == MENU) begin
      rgb = COL_MENU;
    end else if (in_interior) begin
      rgb = (mode_next == OVER) ? COL_OVER : COL_ARENA;
    end else if (in_arena) begin
      rgb = COL_BORDER;
    end else begin
      rgb = COL_OUTSIDE;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      mode <= MENU;
    end else begin
      mode <= mode_next;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      pix_out <= '0;
    end else begin
      pix_out     <= pix_in;
      pix_out.rgb <= rgb;
    end
  end

endmodule

//--- hw/obstacle_mover.sv
`timescale 1ns/1ps

module obstacle_mover #(
  parameter int TOP_LINE    = 120,
  parameter int BOTTOM_LINE = 360,
  parameter int LEFT_LINE   = 160,
  parameter int RIGHT_LINE  = 480,
  parameter int BORDER      = 4,
  parameter int OBS_W       = 32,
  parameter int OBS_H       = 32,
  parameter int OBS_STEP    = 4
) (
  input  logic                 pclk,
  input  logic                 rst,
  input  vga_pkg::pix_t        pix_in,
  input  game_pkg::game_mode_t mode,
  output vga_pkg::coord_t      obs_x,
  output vga_pkg::coord_t      obs_y,
  output vga_pkg::pix_t        pix_out
);

  import vga_pkg::*;
  import game_pkg::*;

  // travel range of the left edge
  localparam int X_MIN = LEFT_LINE + BORDER;
  localparam int X_MAX = RIGHT_LINE - BORDER - OBS_W;
  localparam int Y_MID = (TOP_LINE + BOTTOM_LINE) / 2 - OBS_H / 2;

  coord_t x_next;
  logic   dir;
  logic   dir_next;
  logic   in_box;
  logic   show;

  // dir high means moving right
  always_comb begin
    x_next   = obs_x;
    dir_next = dir;
    if (pix_in.frame_start) begin
      case (mode)
        MENU: begin
          x_next   = coord_t'(X_MIN);
          dir_next = 1'b1;
        end
        PLAY: begin
          if (dir) begin
            if (obs_x + OBS_STEP > X_MAX) begin
              x_next   = coord_t'(X_MAX);
              dir_next = 1'b0;
            end else begin
              x_next = obs_x + coord_t'(OBS_STEP);
            end
          end else begin
            if (obs_x < X_MIN + OBS_STEP) begin
              x_next   = coord_t'(X_MIN);
              dir_next = 1'b1;
            end else begin
              x_next = obs_x - coord_t'(OBS_STEP);
            end
          end
        end
        default: x_next = obs_x;
      endcase
    end
  end

  assign obs_y = coord_t'(Y_MID);

  assign in_box = (pix_in.hcount >= x_next) && (pix_in.hcount < x_next + OBS_W) &&
                  (pix_in.vcount >= obs_y) && (pix_in.vcount < obs_y + OBS_H);

  assign show = ((mode == PLAY) || (mode == OVER)) && !pix_in.hblnk && !pix_in.vblnk &&
                in_box;

  always_ff @(posedge pclk) begin
    if (rst) begin
      obs_x <= coord_t'(X_MIN);
      dir   <= 1'b1;
    end else begin
      obs_x <= x_next;
      dir   <= dir_next;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      pix_out <= '0;
    end else begin
      pix_out <= pix_in;
      if (show) begin
        pix_out.rgb <= COL_OBSTACLE;
      end
    end
  end

endmodule

//--- hw/collision_detector.sv
`timescale 1ns/1ps

module collision_detector #(
  parameter int OBS_W = 32,
  parameter int OBS_H = 32
) (
  input  logic                 pclk,
  input  logic                 rst,
  input  logic                 frame_start,
  input  game_pkg::game_mode_t mode,
  input  vga_pkg::coord_t      obs_x,
  input  vga_pkg::coord_t      obs_y,
  input  vga_pkg::coord_t      player_x,
  input  vga_pkg::coord_t      player_y,
  output logic                 hit
);

  import game_pkg::*;

  logic overlap;

  // same box edges as the drawing
  assign overlap = (player_x >= obs_x) && (player_x < obs_x + OBS_W) &&
                   (player_y >= obs_y) && (player_y < obs_y + OBS_H);

  // one test per frame before the obstacle moves
  always_ff @(posedge pclk) begin
    if (rst) begin
      hit <= 1'b0;
    end else begin
      hit <= frame_start && (mode == PLAY) && overlap;
    end
  end

endmodule

//--- hw/hp_control.sv
`timescale 1ns/1ps

module hp_control #(
  parameter int TOP_LINE  = 120,
  parameter int LEFT_LINE = 160,
  parameter int BORDER    = 4,
  parameter int HP_MAX    = 8
) (
  input  logic                 pclk,
  input  logic                 rst,
  input  vga_pkg::pix_t        pix_in,
  input  game_pkg::game_mode_t mode,
  input  logic                 hit,
  output game_pkg::hp_t        hp,
  output logic                 game_over,
  output vga_pkg::pix_t        pix_out
);

  import vga_pkg::*;
  import game_pkg::*;

  logic   playing;
  coord_t bar_len;
  logic   in_bar;

  assign playing   = (mode == PLAY) || (mode == OVER);
  assign game_over = playing && (hp == '0);

  // four pixels per hit point
  assign bar_len = coord_t'({hp, 2'b00});

  // bar rows sit just above the arena
  assign in_bar = (pix_in.vcount >= TOP_LINE - BORDER) && (pix_in.vcount < TOP_LINE) &&
                  (pix_in.hcount >= LEFT_LINE) && (pix_in.hcount < LEFT_LINE + bar_len);

  always_ff @(posedge pclk) begin
    if (rst) begin
      hp <= hp_t'(HP_MAX);
    end else if (mode == MENU) begin
      hp <= hp_t'(HP_MAX);
    end else if (hit && (hp != '0)) begin
      hp <= hp - 1'b1;
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      pix_out <= '0;
    end else begin
      pix_out <= pix_in;
      if (playing && in_bar && !pix_in.hblnk && !pix_in.vblnk) begin
        pix_out.rgb <= COL_HP;
      end
    end
  end

endmodule

//--- hw/vga_game_top.sv
`timescale 1ns/1ps

module vga_game_top #(
  parameter int H_ACTIVE    = 640,
  parameter int H_FRONT     = 16,
  parameter int H_SYNC      = 96,
  parameter int H_BACK      = 48,
  parameter int V_ACTIVE    = 480,
  parameter int V_FRONT     = 10,
  parameter int V_SYNC      = 2,
  parameter int V_BACK      = 33,
  parameter int TOP_LINE    = 120,
  parameter int BOTTOM_LINE = 360,
  parameter int LEFT_LINE   = 160,
  parameter int RIGHT_LINE  = 480,
  parameter int BORDER      = 4,
  parameter int OBS_W       = 32,
  parameter int OBS_H       = 32,
  parameter int OBS_STEP    = 4,
  parameter int HP_MAX      = 8
) (
  input  logic            pclk,
  input  logic            rst,
  input  logic            game_button,
  input  logic            menu_button,
  input  vga_pkg::coord_t player_x,
  input  vga_pkg::coord_t player_y,
  output vga_pkg::pix_t   pix,
  output vga_pkg::coord_t obs_x,
  output vga_pkg::coord_t obs_y,
  output game_pkg::hp_t   hp,
  output logic            game_over
);

  import vga_pkg::*;
  import game_pkg::*;

  pix_t       pix_tim;
  pix_t       pix_bg;
  pix_t       pix_obs;
  game_mode_t mode;
  logic       hit;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) u_timing (
    .pclk (pclk),
    .rst  (rst),
    .pix  (pix_tim)
  );

  draw_background #(
    .TOP_LINE(TOP_LINE), .BOTTOM_LINE(BOTTOM_LINE),
    .LEFT_LINE(LEFT_LINE), .RIGHT_LINE(RIGHT_LINE),
    .BORDER(BORDER)
  ) u_background (
    .pclk        (pclk),
    .rst         (rst),
    .pix_in      (pix_tim),
    .game_button (game_button),
    .menu_button (menu_button),
    .game_over   (game_over),
    .mode        (mode),
    .pix_out     (pix_bg)
  );

  obstacle_mover #(
    .TOP_LINE(TOP_LINE), .BOTTOM_LINE(BOTTOM_LINE),
    .LEFT_LINE(LEFT_LINE), .RIGHT_LINE(RIGHT_LINE),
    .BORDER(BORDER), .OBS_W(OBS_W), .OBS_H(OBS_H), .OBS_STEP(OBS_STEP)
  ) u_obstacle (
    .pclk    (pclk),
    .rst     (rst),
    .pix_in  (pix_bg),
    .mode    (mode),
    .obs_x   (obs_x),
    .obs_y   (obs_y),
    .pix_out (pix_obs)
  );

  // frame strobe straight from the timing stage
  collision_detector #(
    .OBS_W(OBS_W), .OBS_H(OBS_H)
  ) u_collision (
    .pclk        (pclk),
    .rst         (rst),
    .frame_start (pix_tim.frame_start),
    .mode        (mode),
    .obs_x       (obs_x),
    .obs_y       (obs_y),
    .player_x    (player_x),
    .player_y    (player_y),
    .hit         (hit)
  );

  hp_control #(
    .TOP_LINE(TOP_LINE), .LEFT_LINE(LEFT_LINE),
    .BORDER(BORDER), .HP_MAX(HP_MAX)
  ) u_hp (
    .pclk      (pclk),
    .rst       (rst),
    .pix_in    (pix_obs),
    .mode      (mode),
    .hit       (hit),
    .hp        (hp),
    .game_over (game_over),
    .pix_out   (pix)
  );

endmodule

//--- sim/tb_vga_game.sv
`timescale 1ns/1ps

module tb_vga_game;

  import vga_pkg::*;
  import game_pkg::*;

  localparam int H_ACTIVE    = 32;
  localparam int H_FRONT     = 2;
  localparam int H_SYNC      = 4;
  localparam int H_BACK      = 2;
  localparam int V_ACTIVE    = 24;
  localparam int V_FRONT     = 1;
  localparam int V_SYNC      = 2;
  localparam int V_BACK      = 1;
  localparam int TOP_LINE    = 4;
  localparam int BOTTOM_LINE = 22;
  localparam int LEFT_LINE   = 2;
  localparam int RIGHT_LINE  = 30;
  localparam int BORDER      = 2;
  localparam int OBS_W       = 6;
  localparam int OBS_H       = 4;
  localparam int OBS_STEP    = 5;
  localparam int HP_MAX      = 3;

  localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
  localparam int X_MIN     = LEFT_LINE + BORDER;
  localparam int X_MAX     = RIGHT_LINE - BORDER - OBS_W;
  // obstacle box centred on the arena's middle line
  localparam int Y_MID     = (TOP_LINE + BOTTOM_LINE) / 2 - OBS_H / 2;
  localparam int NUM_ROWS  = 8;

  typedef struct packed {
    logic       game;
    logic       menu;
    coord_t     px;
    coord_t     py;
    logic [7:0] frames;
  } step_t;

  logic       pclk;
  logic       rst;
  logic       game_button;
  logic       menu_button;
  coord_t     player_x;
  coord_t     player_y;
  pix_t       pix;
  coord_t     obs_x;
  coord_t     obs_y;
  hp_t        hp;
  logic       game_over;

  step_t      steps [NUM_ROWS];
  game_mode_t m_mode;
  int         m_x;
  logic       m_dir;
  int         m_hp;
  int         exp_h;
  int         exp_v;
  logic       started;
  logic       saw_over;
  logic       saw_left;
  logic       saw_right;
  int         cycle_count = 0;
  int         cycle_limit = 0;

  vga_game_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .TOP_LINE(TOP_LINE), .BOTTOM_LINE(BOTTOM_LINE),
    .LEFT_LINE(LEFT_LINE), .RIGHT_LINE(RIGHT_LINE), .BORDER(BORDER),
    .OBS_W(OBS_W), .OBS_H(OBS_H), .OBS_STEP(OBS_STEP), .HP_MAX(HP_MAX)
  ) uut (
    .pclk        (pclk),
    .rst         (rst),
    .game_button (game_button),
    .menu_button (menu_button),
    .player_x    (player_x),
    .player_y    (player_y),
    .pix         (pix),
    .obs_x       (obs_x),
    .obs_y       (obs_y),
    .hp          (hp),
    .game_over   (game_over)
  );

  initial begin
    pclk = 1'b0;
    forever #50 pclk = ~pclk;
  end

  always @(posedge pclk) begin
    cycle_count = cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
      $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("STATUS: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic stop_on_error(input string msg);
    $display("FAIL %0t ns: %s", $time, msg);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_rgb(input rgb_t got, input rgb_t exp, input int h, input int v);
    if (got !== exp) begin
      stop_on_error($sformatf("rgb at (%0d,%0d) is %h, expected %h", h, v, got, exp));
    end
  endtask

  task automatic check_coord(input coord_t got, input coord_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_hp(input hp_t got, input hp_t exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("%s is %b, expected %b at (%0d,%0d)", what, got, exp,
                              exp_h, exp_v));
    end
  endtask

  // columns are game level, menu level, player x, player y and frames
  task automatic load_steps();
    steps[0] = '{game: 1'b0, menu: 1'b0, px: 12'd0,  py: 12'd0,  frames: 8'd3};
    steps[1] = '{game: 1'b1, menu: 1'b0, px: 12'd0,  py: 12'd0,  frames: 8'd1};
    steps[2] = '{game: 1'b0, menu: 1'b0, px: 12'd0,  py: 12'd0,  frames: 8'd10};
    steps[3] = '{game: 1'b0, menu: 1'b0, px: 12'd20, py: 12'd12, frames: 8'd16};
    steps[4] = '{game: 1'b0, menu: 1'b1, px: 12'd0,  py: 12'd0,  frames: 8'd2};
    steps[5] = '{game: 1'b0, menu: 1'b0, px: 12'd0,  py: 12'd0,  frames: 8'd3};
    steps[6] = '{game: 1'b1, menu: 1'b0, px: 12'd0,  py: 12'd0,  frames: 8'd1};
    steps[7] = '{game: 1'b0, menu: 1'b0, px: 12'd0,  py: 12'd0,  frames: 8'd4};
  endtask

  // game state of the starting frame derived from the previous frame
  task automatic advance_model();
    logic       hit;
    game_mode_t next;
    int         px;
    int         py;
    px  = player_x;
    py  = player_y;
    hit = (m_mode == PLAY) && (px >= m_x) && (px < m_x + OBS_W) &&
          (py >= Y_MID) && (py < Y_MID + OBS_H);
    if (menu_button) begin
      next = MENU;
    end else if ((m_mode == MENU) && game_button) begin
      next = PLAY;
    end else if ((m_mode == PLAY) && (m_hp == 0)) begin
      next = OVER;
    end else begin
      next = m_mode;
    end
    m_mode = next;
    if (m_mode == OVER) saw_over = 1'b1;
    if (m_mode == MENU) begin
      m_x   = X_MIN;
      m_dir = 1'b1;
      m_hp  = HP_MAX;
    end else begin
      if (m_mode == PLAY) begin
        if (m_dir && (m_x + OBS_STEP > X_MAX)) begin
          m_x       = X_MAX;
          m_dir     = 1'b0;
          saw_right = 1'b1;
        end else if (m_dir) begin
          m_x = m_x + OBS_STEP;
        end else if (m_x - OBS_STEP < X_MIN) begin
          m_x      = X_MIN;
          m_dir    = 1'b1;
          saw_left = 1'b1;
        end else begin
          m_x = m_x - OBS_STEP;
        end
      end
      if (hit && (m_hp > 0)) m_hp = m_hp - 1;
    end
  endtask

  function automatic rgb_t expected_rgb(input int h, input int v);
    rgb_t c;
    logic arena;
    logic interior;
    arena    = (h >= LEFT_LINE) && (h < RIGHT_LINE) && (v >= TOP_LINE) && (v < BOTTOM_LINE);
    interior = (h >= LEFT_LINE + BORDER) && (h < RIGHT_LINE - BORDER) &&
               (v >= TOP_LINE + BORDER) && (v < BOTTOM_LINE - BORDER);
    if ((h >= H_ACTIVE) || (v >= V_ACTIVE)) begin
      c = RGB_BLACK;
    end else if (m_mode == MENU) begin
      c = COL_MENU;
    end else begin
      if (interior) begin
        c = (m_mode == OVER) ? COL_OVER : COL_ARENA;
      end else if (arena) begin
        c = COL_BORDER;
      end else begin
        c = COL_OUTSIDE;
      end
      if ((h >= m_x) && (h < m_x + OBS_W) && (v >= Y_MID) && (v < Y_MID + OBS_H)) begin
        c = COL_OBSTACLE;
      end
      // health bar of four pixels per point
      if ((v >= TOP_LINE - BORDER) && (v < TOP_LINE) && (h >= LEFT_LINE) &&
          (h < LEFT_LINE + 4 * m_hp)) begin
        c = COL_HP;
      end
    end
    return c;
  endfunction

  task automatic check_pixel();
    check_coord(pix.hcount, coord_t'(exp_h), "hcount");
    check_coord(pix.vcount, coord_t'(exp_v), "vcount");
    check_flag(pix.frame_start, (exp_h == 0) && (exp_v == 0), "frame_start");
    if (pix.frame_start) begin
      advance_model();
      check_coord(obs_x, coord_t'(m_x), "obs_x");
      check_coord(obs_y, coord_t'(Y_MID), "obs_y");
      check_hp(hp, hp_t'(m_hp), "hp");
      check_flag(game_over, (m_mode != MENU) && (m_hp == 0), "game_over");
    end
    check_flag(pix.hsync, (exp_h >= H_ACTIVE + H_FRONT) &&
               (exp_h < H_ACTIVE + H_FRONT + H_SYNC), "hsync");
    check_flag(pix.vsync, (exp_v >= V_ACTIVE + V_FRONT) &&
               (exp_v < V_ACTIVE + V_FRONT + V_SYNC), "vsync");
    check_flag(pix.hblnk, exp_h >= H_ACTIVE, "hblnk");
    check_flag(pix.vblnk, exp_v >= V_ACTIVE, "vblnk");
    check_rgb(pix.rgb, expected_rgb(exp_h, exp_v), exp_h, exp_v);
  endtask

  // one clock with outputs sampled 1 ns after the edge
  task automatic tick();
    @(posedge pclk);
    #1;
    if (started) begin
      if (exp_h == H_TOTAL - 1) begin
        exp_h = 0;
        exp_v = (exp_v == V_TOTAL - 1) ? 0 : exp_v + 1;
      end else begin
        exp_h = exp_h + 1;
      end
    end else if (pix.frame_start) begin
      started = 1'b1;
      exp_h   = 0;
      exp_v   = 0;
    end
    if (started) check_pixel();
  endtask

  task automatic wait_frame_start();
    do begin
      tick();
    end while (!pix.frame_start);
  endtask

  task automatic apply_step(input step_t s);
    game_button = s.game;
    menu_button = s.menu;
    player_x    = s.px;
    player_y    = s.py;
  endtask

  initial begin
    int total;
    rst         = 1'b1;
    game_button = 1'b0;
    menu_button = 1'b0;
    player_x    = '0;
    player_y    = '0;
    m_mode      = MENU;
    m_x         = X_MIN;
    m_dir       = 1'b1;
    m_hp        = HP_MAX;
    exp_h       = 0;
    exp_v       = 0;
    started     = 1'b0;
    saw_over    = 1'b0;
    saw_left    = 1'b0;
    saw_right   = 1'b0;
    load_steps();
    total = 0;
    foreach (steps[i]) total = total + steps[i].frames;
    cycle_limit = (total * FRAME_LEN * 6) / 5;
    repeat (2) @(posedge pclk);
    #1;
    rst = 1'b0;
    // new inputs take effect from the following frame
    foreach (steps[i]) begin
      for (int f = 0; f < steps[i].frames; f++) begin
        wait_frame_start();
        apply_step(steps[i]);
      end
    end
    wait_frame_start();
    wait_frame_start();
    if (!saw_over || !saw_left || !saw_right) begin
      $display("scenario incomplete: game over or a bounce at one of the bounds never happened");
      $display("STATUS: FAIL");
      $fatal(1, "scenario did not cover all behaviors");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

//--- vga_game.f
hw/vga_pkg.sv
hw/game_pkg.sv
hw/vga_timing.sv
hw/draw_background.sv
hw/obstacle_mover.sv
hw/collision_detector.sv
hw/hp_control.sv
hw/vga_game_top.sv
sim/tb_vga_game.sv

//--- Bender.yml
package:
  name: vga_game

sources:
  - hw/vga_pkg.sv
  - hw/game_pkg.sv
  - hw/vga_timing.sv
  - hw/draw_background.sv
  - hw/obstacle_mover.sv
  - hw/collision_detector.sv
  - hw/hp_control.sv
  - hw/vga_game_top.sv
  - target: simulation
    files:
      - sim/tb_vga_game.sv
